/* logic/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  localparam int data_width = 8;
  localparam int addr_width = 16;

  typedef logic [data_width-1:0] data_t;
  typedef logic [addr_width-1:0] addr_t;

  // Native 6502 encodings.
  typedef enum logic [7:0] {
    op_lda_imm = 8'hA9,
    op_lda_zpg = 8'hA5,
    op_ldx_imm = 8'hA2,
    op_ldy_imm = 8'hA0,
    op_sta_zpg = 8'h85,
    op_stx_zpg = 8'h86,
    op_adc_imm = 8'h69,
    op_sbc_imm = 8'hE9,
    op_and_imm = 8'h29,
    op_ora_imm = 8'h09,
    op_eor_imm = 8'h49,
    op_clc     = 8'h18,
    op_sec     = 8'h38,
    op_tax     = 8'hAA,
    op_txa     = 8'h8A,
    op_inx     = 8'hE8,
    op_jmp_abs = 8'h4C,
    op_nop     = 8'hEA
  } opcode_t;

  typedef enum logic [2:0] {st_fetch, st_decode, st_operand, st_addr_high, st_execute} state_t;

  typedef enum logic [1:0] {alu_add, alu_and, alu_or, alu_xor} alu_op_t;

  typedef enum logic [1:0] {src_mem, src_a, src_x, src_alu} data_src_t;

  typedef enum logic [1:0] {addr_pc, addr_zpg, addr_jump} addr_src_t;

  typedef struct packed {
    data_src_t data_src;
    addr_src_t addr_src;
    alu_op_t   alu_op;
    logic      alu_carry_in_sel;  // Selects X plus zero with a carry in of one.
    logic      invert_b;
    logic      load_a;
    logic      load_x;
    logic      load_y;
    logic      load_addr_low;
    logic      load_carry;
    logic      set_carry;
    logic      clear_carry;
    logic      pc_inc;
    logic      pc_load;
    logic      mem_write;
  } ctrl_t;

  typedef struct packed {
    addr_t addr;
    data_t wdata;
    logic  write;
  } mem_req_t;

endpackage

`default_nettype wire

/* logic/cpu_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_alu (
  input  cpu_pkg::alu_op_t op,
  input  cpu_pkg::data_t   a,
  input  cpu_pkg::data_t   b,
  input  logic             carry_in,
  input  logic             invert_b,
  output cpu_pkg::data_t   result,
  output logic             carry_out
);
  import cpu_pkg::*;

  data_t               b_eff;
  logic [data_width:0] sum;

  // Subtract is add of the ones complement.
  assign b_eff = invert_b ? ~b : b;
  assign sum   = {1'b0, a} + {1'b0, b_eff} + {{data_width{1'b0}}, carry_in};

  always_comb begin
    carry_out = 1'b0;  // Logic ops leave no carry.
    case (op)
      alu_add: begin
        result    = sum[data_width-1:0];
        carry_out = sum[data_width];
      end
      alu_and: result = a & b_eff;
      alu_or:  result = a | b_eff;
      default: result = a ^ b_eff;
    endcase
  end

endmodule

`default_nettype wire

/* logic/cpu_datapath.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_datapath #(
  parameter cpu_pkg::addr_t reset_pc = 16'h0200
) (
  input  logic           clk,
  input  logic           reset,
  input  cpu_pkg::ctrl_t ctrl,
  input  cpu_pkg::data_t mem_rdata,
  output cpu_pkg::addr_t addr,
  output cpu_pkg::data_t wdata
);
  import cpu_pkg::*;

  data_t acc;
  data_t x_reg;
  data_t y_reg;
  addr_t pc;
  data_t addr_low;
  logic  carry;
  data_t data_bus;
  data_t alu_a;
  data_t alu_b;
  logic  alu_cin;
  data_t alu_result;
  logic  alu_carry;

  always_comb begin
    case (ctrl.data_src)
      src_a:   data_bus = acc;
      src_x:   data_bus = x_reg;
      src_alu: data_bus = alu_result;
      default: data_bus = mem_rdata;
    endcase
  end

  always_comb begin
    case (ctrl.addr_src)
      addr_zpg: addr = {{(addr_width - data_width){1'b0}}, addr_low};
      default:  addr = pc;  // Fetch, operands and the jump target.
    endcase
  end

  assign wdata = data_bus;

  // INX runs X + 0 + 1 through the adder.
  assign alu_a   = ctrl.alu_carry_in_sel ? x_reg : acc;
  assign alu_b   = ctrl.alu_carry_in_sel ? '0 : mem_rdata;
  assign alu_cin = ctrl.alu_carry_in_sel | carry;

  cpu_alu u_alu (
    .op        (ctrl.alu_op),
    .a         (alu_a),
    .b         (alu_b),
    .carry_in  (alu_cin),
    .invert_b  (ctrl.invert_b),
    .result    (alu_result),
    .carry_out (alu_carry)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      acc   <= '0;
      x_reg <= '0;
      y_reg <= '0;
      carry <= 1'b0;
      pc    <= reset_pc;
    end else begin
      if (ctrl.load_a) acc <= data_bus;
      if (ctrl.load_x) x_reg <= data_bus;
      if (ctrl.load_y) y_reg <= data_bus;
      if (ctrl.load_carry) begin
        carry <= alu_carry;
      end else if (ctrl.set_carry) begin
        carry <= 1'b1;
      end else if (ctrl.clear_carry) begin
        carry <= 1'b0;
      end
      if (ctrl.pc_load) begin
        pc <= {mem_rdata, addr_low};  // High byte arrives last.
      end else if (ctrl.pc_inc) begin
        pc <= pc + addr_t'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.load_addr_low) addr_low <= mem_rdata;
  end

endmodule

`default_nettype wire

/* logic/instruction_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module instruction_sequencer (
  input  logic           clk,
  input  logic           reset,
  input  logic           mem_ready,
  input  cpu_pkg::data_t mem_rdata,
  output logic           mem_valid,
  output cpu_pkg::ctrl_t ctrl
);
  import cpu_pkg::*;

  typedef enum logic [2:0] {mode_impl, mode_imm, mode_zpg, mode_abs, mode_bad} mode_t;

  state_t  state;
  state_t  next_state;
  opcode_t ir;
  mode_t   mode;
  mode_t   fetch_mode;
  logic    run;        // Low only in the first cycle out of reset.
  logic    need_xfer;
  logic    go;         // State work is done this cycle.

  function automatic mode_t mode_of(opcode_t op);
    case (op)
      op_lda_imm, op_ldx_imm, op_ldy_imm, op_adc_imm, op_sbc_imm,
      op_and_imm, op_ora_imm, op_eor_imm:         mode_of = mode_imm;
      op_lda_zpg, op_sta_zpg, op_stx_zpg:         mode_of = mode_zpg;
      op_jmp_abs:                                 mode_of = mode_abs;
      op_clc, op_sec, op_tax, op_txa, op_inx,
      op_nop:                                     mode_of = mode_impl;
      default:                                    mode_of = mode_bad;
    endcase
  endfunction

  assign mode       = mode_of(ir);
  assign fetch_mode = mode_of(opcode_t'(mem_rdata));

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_fetch;
      run   <= 1'b0;
    end else begin
      state <= next_state;
      run   <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_fetch && go) begin
      ir <= opcode_t'(mem_rdata);
    end
  end

  // Which states put a transfer on the memory port.
  always_comb begin
    case (state)
      st_fetch:     need_xfer = 1'b1;
      st_decode:    need_xfer = (mode == mode_zpg) || (mode == mode_abs);
      st_addr_high: need_xfer = 1'b1;
      st_execute:   need_xfer = (mode == mode_imm) || (mode == mode_zpg);
      default:      need_xfer = 1'b0;
    endcase
  end

  assign mem_valid = need_xfer && run;
  assign go        = run && (!need_xfer || mem_ready);

  always_comb begin
    next_state = state;  // Hold while the memory stalls.
    if (go) begin
      case (state)
        st_fetch: begin
          case (fetch_mode)
            mode_impl: next_state = st_execute;
            mode_bad:  next_state = st_fetch;  // Unknown opcode acts as NOP.
            default:   next_state = st_decode;
          endcase
        end
        st_decode: begin
          case (mode)
            mode_zpg: next_state = st_operand;
            mode_abs: next_state = st_addr_high;
            default:  next_state = st_execute;
          endcase
        end
        st_operand:   next_state = st_execute;
        st_addr_high: next_state = st_execute;
        default:      next_state = st_fetch;
      endcase
    end
  end

  always_comb begin
    ctrl = '0;  // Memory onto the bus, PC on the address, add.
    case (state)
      st_fetch: ctrl.pc_inc = go;
      st_decode: begin
        if (need_xfer) begin
          ctrl.load_addr_low = go;  // Zero-page address or jump low byte.
          ctrl.pc_inc        = go;
        end
      end
      st_operand:   ctrl.addr_src = addr_zpg;
      st_addr_high: ctrl.pc_load = go;
      st_execute: begin
        if (mode == mode_zpg) ctrl.addr_src = addr_zpg;
        if (mode == mode_imm) ctrl.pc_inc = go;
        case (ir)
          op_lda_imm, op_lda_zpg: ctrl.load_a = go;
          op_ldx_imm:             ctrl.load_x = go;
          op_ldy_imm:             ctrl.load_y = go;
          op_sta_zpg: begin
            ctrl.data_src  = src_a;
            ctrl.mem_write = 1'b1;
          end
          op_stx_zpg: begin
            ctrl.data_src  = src_x;
            ctrl.mem_write = 1'b1;
          end
          op_adc_imm, op_sbc_imm: begin
            ctrl.data_src   = src_alu;
            ctrl.invert_b   = (ir == op_sbc_imm);  // A + ~M + C.
            ctrl.load_a     = go;
            ctrl.load_carry = go;
          end
          op_and_imm, op_ora_imm, op_eor_imm: begin
            ctrl.data_src = src_alu;
            ctrl.alu_op   = (ir == op_and_imm) ? alu_and :
                            (ir == op_ora_imm) ? alu_or : alu_xor;
            ctrl.load_a   = go;
          end
          op_clc: ctrl.clear_carry = go;
          op_sec: ctrl.set_carry = go;
          op_tax: begin
            ctrl.data_src = src_a;
            ctrl.load_x   = go;
          end
          op_txa: begin
            ctrl.data_src = src_x;
            ctrl.load_a   = go;
          end
          op_inx: begin
            ctrl.data_src         = src_alu;
            ctrl.alu_carry_in_sel = 1'b1;
            ctrl.load_x           = go;
          end
          op_jmp_abs: ctrl.addr_src = addr_jump;  // PC already holds the target.
          default: ;
        endcase
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* logic/cpu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_top #(
  parameter cpu_pkg::addr_t reset_pc = 16'h0200
) (
  input  logic              clk,
  input  logic              reset,
  output cpu_pkg::mem_req_t mem_req,
  output logic              mem_valid,
  input  logic              mem_ready,
  input  cpu_pkg::data_t    mem_rdata
);
  import cpu_pkg::*;

  ctrl_t ctrl;
  addr_t addr;
  data_t wdata;

  instruction_sequencer u_sequencer (
    .clk       (clk),
    .reset     (reset),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .mem_valid (mem_valid),
    .ctrl      (ctrl)
  );

  cpu_datapath #(
    .reset_pc (reset_pc)
  ) u_datapath (
    .clk       (clk),
    .reset     (reset),
    .ctrl      (ctrl),
    .mem_rdata (mem_rdata),
    .addr      (addr),
    .wdata     (wdata)
  );

  assign mem_req = '{addr: addr, wdata: wdata, write: ctrl.mem_write};

endmodule

`default_nettype wire

/* testbench/mem_model.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_model (
  input  logic              clk,
  input  logic              reset,
  input  logic              stall_en,
  input  logic              load_en,
  input  cpu_pkg::addr_t    load_addr,
  input  cpu_pkg::data_t    load_data,
  input  cpu_pkg::mem_req_t mem_req,
  input  logic              mem_valid,
  output logic              mem_ready,
  output cpu_pkg::data_t    mem_rdata
);
  import cpu_pkg::*;

  data_t       mem [0:65535];
  addr_t       log_addr [0:63];
  data_t       log_data [0:63];
  int          write_count;
  int          stall_count;  // Cycles with a request waiting on ready.
  integer      seed;
  logic [31:0] rnd;
  logic        ready_draw;
  logic        fire;

  initial seed = 39641;

  assign fire      = mem_valid && mem_ready;
  assign mem_ready = !stall_en || ready_draw;
  assign mem_rdata = mem[mem_req.addr];  // Read data is valid in the handshake cycle.

  always @(posedge clk) begin
    rnd = $random(seed);
    ready_draw <= rnd[0];  // High about half the time.
  end

  always @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end else if (fire && mem_req.write) begin
      mem[mem_req.addr] <= mem_req.wdata;
    end
  end

  // The write log is cleared while the CPU is held in reset.
  always @(posedge clk) begin
    if (reset) begin
      write_count <= 0;
      stall_count <= 0;
    end else begin
      if (fire && mem_req.write) begin
        if (write_count < 64) begin
          log_addr[write_count[5:0]] <= mem_req.addr;
          log_data[write_count[5:0]] <= mem_req.wdata;
        end
        write_count <= write_count + 1;
      end
      if (mem_valid && !mem_ready) stall_count <= stall_count + 1;
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_cpu.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cpu;
  import cpu_pkg::*;

  localparam addr_t reset_pc   = 16'h0200;
  localparam addr_t far_target = 16'h4A60;
  localparam int    wait_limit = 1000;

  logic     clk;
  logic     reset;
  logic     stall_en;
  logic     load_en;
  addr_t    load_addr;
  data_t    load_data;
  mem_req_t mem_req;
  logic     mem_valid;
  logic     mem_ready;
  data_t    mem_rdata;

  addr_t  load_ptr;
  integer seed;
  int     errors;  // Errors in the running test.
  int     passed;
  int     failed;
  data_t  arith_a [0:1];
  data_t  arith_b [0:1];
  logic   arith_c [0:1];

  cpu_top #(.reset_pc(reset_pc)) u_cpu_top (
    .clk(clk), .reset(reset),
    .mem_req(mem_req), .mem_valid(mem_valid),
    .mem_ready(mem_ready), .mem_rdata(mem_rdata)
  );

  mem_model u_mem (
    .clk(clk), .reset(reset), .stall_en(stall_en),
    .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
    .mem_req(mem_req), .mem_valid(mem_valid),
    .mem_ready(mem_ready), .mem_rdata(mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic emit(input data_t value);
    @(posedge clk);
    load_en   <= 1'b1;
    load_addr <= load_ptr;
    load_data <= value;
    load_ptr  = load_ptr + addr_t'(1);
  endtask

  task automatic op2(input opcode_t op, input data_t operand);
    emit(op);
    emit(operand);
  endtask

  // Jump to itself, so the CPU idles without further writes.
  task automatic emit_halt;
    addr_t here;
    here = load_ptr;
    emit(op_jmp_abs);
    emit(here[7:0]);
    emit(here[15:8]);
  endtask

  task automatic begin_program(input logic stall);
    @(posedge clk);
    reset    <= 1'b1;
    stall_en <= stall;
    load_ptr = reset_pc;
    errors   = 0;
  endtask

  task automatic run_program;
    @(posedge clk);
    load_en <= 1'b0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic wait_writes(input string name, input int count);
    int cycles;
    cycles = 0;
    while (u_mem.write_count < count && cycles < wait_limit) begin
      @(posedge clk);
      cycles = cycles + 1;
    end
    if (u_mem.write_count < count) begin
      $display("%s: timed out, only %0d of %0d writes arrived",
               name, u_mem.write_count, count);
      errors = errors + 1;
    end
  endtask

  task automatic check_write(input string name, input int idx, input addr_t addr,
                             input data_t data);
    if (idx < u_mem.write_count) begin
      if ({u_mem.log_addr[idx[5:0]], u_mem.log_data[idx[5:0]]} !== {addr, data}) begin
        $display("ERROR %s write %0d: expected %h:%h actual %h:%h", name, idx,
                 addr, data, u_mem.log_addr[idx[5:0]], u_mem.log_data[idx[5:0]]);
        errors = errors + 1;
      end
    end
  endtask

  task automatic finish_test(input string name);
    if (errors == 0) begin
      passed = passed + 1;
      $display("%s: passed", name);
    end else begin
      failed = failed + 1;
      $display("%s: failed with %0d errors", name, errors);
    end
  endtask

  task automatic test_load_store;
    data_t v1;
    data_t v2;
    v1 = data_t'($random(seed));
    v2 = data_t'($random(seed));
    begin_program(1'b0);
    op2(op_lda_imm, v1);
    op2(op_sta_zpg, 8'h10);
    op2(op_ldx_imm, v2);
    op2(op_stx_zpg, 8'h11);
    op2(op_lda_imm, ~v1);  // LDA zpg must bring v1 back.
    op2(op_lda_zpg, 8'h10);
    op2(op_sta_zpg, 8'h12);
    emit_halt();
    run_program();
    wait_writes("load_store", 3);
    check_write("load_store", 0, 16'h0010, v1);
    check_write("load_store", 1, 16'h0011, v2);
    check_write("load_store", 2, 16'h0012, v1);
    finish_test("load_store");
  endtask

  task automatic pick_operands;
    logic [31:0] r;
    r = $random(seed);
    arith_a[0] = r[7:0];
    arith_b[0] = r[15:8];
    arith_a[1] = r[23:16];
    arith_b[1] = r[31:24];
    r = $random(seed);
    arith_c[0] = r[0];
    arith_c[1] = ~r[0];  // One run with SEC and one with CLC.
  endtask

  // Stores the result, then the carry out read back by ADC of zero.
  task automatic emit_arith(input opcode_t op, input logic n, input data_t zp);
    emit(arith_c[n] ? op_sec : op_clc);
    op2(op_lda_imm, arith_a[n]);
    op2(op, arith_b[n]);
    op2(op_sta_zpg, zp);
    op2(op_lda_imm, 8'h00);
    op2(op_adc_imm, 8'h00);
    op2(op_sta_zpg, zp + 8'h01);
  endtask

  task automatic test_arith(input logic stall, input string name);
    logic [8:0] sum;
    begin_program(stall);
    emit_arith(op_adc_imm, 1'b0, 8'h20);
    emit_arith(op_sbc_imm, 1'b1, 8'h22);
    emit_halt();
    run_program();
    wait_writes(name, 4);
    sum = {1'b0, arith_a[0]} + {1'b0, arith_b[0]} + {8'h00, arith_c[0]};
    check_write(name, 0, 16'h0020, sum[7:0]);
    check_write(name, 1, 16'h0021, {7'h00, sum[8]});
    sum = {1'b0, arith_a[1]} + {1'b0, ~arith_b[1]} + {8'h00, arith_c[1]};
    check_write(name, 2, 16'h0022, sum[7:0]);
    check_write(name, 3, 16'h0023, {7'h00, sum[8]});
    if (stall && u_mem.stall_count == 0) begin
      $display("%s: the memory never held a request back", name);
      errors = errors + 1;
    end
    finish_test(name);
  endtask

  task automatic test_logic;
    data_t a;
    data_t m;
    a = data_t'($random(seed));
    m = data_t'($random(seed));
    begin_program(1'b0);
    op2(op_lda_imm, a);
    op2(op_and_imm, m);
    op2(op_sta_zpg, 8'h30);
    op2(op_lda_imm, a);
    op2(op_ora_imm, m);
    op2(op_sta_zpg, 8'h31);
    op2(op_lda_imm, a);
    op2(op_eor_imm, m);
    op2(op_sta_zpg, 8'h32);
    emit_halt();
    run_program();
    wait_writes("logic", 3);
    check_write("logic", 0, 16'h0030, a & m);
    check_write("logic", 1, 16'h0031, a | m);
    check_write("logic", 2, 16'h0032, a ^ m);
    finish_test("logic");
  endtask

  task automatic test_transfer;
    data_t x;
    data_t v;
    x = data_t'($random(seed));
    v = data_t'($random(seed));
    begin_program(1'b0);
    op2(op_ldx_imm, x);
    emit(op_inx);
    emit(op_txa);
    op2(op_sta_zpg, 8'h40);
    op2(op_lda_imm, v);
    emit(op_tax);
    op2(op_stx_zpg, 8'h41);
    op2(op_ldy_imm, ~v);  // A must still hold v afterwards.
    op2(op_sta_zpg, 8'h42);
    emit_halt();
    run_program();
    wait_writes("transfer", 3);
    check_write("transfer", 0, 16'h0040, x + 8'h01);
    check_write("transfer", 1, 16'h0041, v);
    check_write("transfer", 2, 16'h0042, v);
    finish_test("transfer");
  endtask

  task automatic test_control;
    begin_program(1'b0);
    op2(op_jmp_abs, far_target[7:0]);
    emit(far_target[15:8]);
    op2(op_lda_imm, 8'h11);
    op2(op_sta_zpg, 8'h51);  // Skipped by the jump.
    emit_halt();
    load_ptr = far_target;
    emit(op_nop);
    emit(8'hFF);  // Undefined opcode.
    op2(op_lda_imm, 8'h5A);
    op2(op_sta_zpg, 8'h50);
    emit_halt();
    run_program();
    wait_writes("control", 1);
    repeat (40) @(posedge clk);
    if (u_mem.write_count != 1) begin
      $display("ERROR control write count: expected 1 actual %0d", u_mem.write_count);
      errors = errors + 1;
    end
    check_write("control", 0, 16'h0050, 8'h5A);
    finish_test("control");
  endtask

  initial begin
    reset     = 1'b1;
    stall_en  = 1'b0;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    load_ptr  = reset_pc;
    seed      = 39641;
    errors    = 0;
    passed    = 0;
    failed    = 0;
    repeat (5) @(posedge clk);
    test_load_store();
    pick_operands();
    test_arith(1'b0, "arith");
    test_logic();
    test_transfer();
    test_control();
    test_arith(1'b1, "backpressure");  // Reruns the arithmetic with ready low half the time.
    $display("%0d tests passed, %0d tests failed", passed, failed);
    if (failed == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
logic/cpu_pkg.sv
logic/cpu_alu.sv
logic/cpu_datapath.sv
logic/instruction_sequencer.sv
logic/cpu_top.sv
testbench/mem_model.sv
testbench/tb_cpu.sv

/* run.sh */
#!/usr/bin/env bash
# Build the CPU testbench with Verilator, run it and look for the pass line.
cd "$(dirname "$0")" &&
  verilator --binary --timing -f tb.f --top-module tb_cpu -o tb_cpu_sim &&
  ./obj_dir/tb_cpu_sim | tee /dev/stderr | grep -qx "TEST OK" &&
  echo "Simulation passed." ||
  { echo "Simulation failed."; exit 1; }
